/* hw/zx_bus_pkg.sv */
package zx_bus_pkg;

	////////////////////////////////////////////////////////////
	// cpu side bus
	////////////////////////////////////////////////////////////

	// kinds of cpu bus cycle
	typedef enum logic [2:0] {
		MEM_RD = 3'd0,
		MEM_WR = 3'd1,
		FETCH  = 3'd2,
		IO_RD  = 3'd3,
		IO_WR  = 3'd4
	} req_kind_e;

	localparam int CPU_AW = 16;
	localparam int DATA_W = 8;

	////////////////////////////////////////////////////////////
	// memory side
	////////////////////////////////////////////////////////////

	localparam int PHYS_AW = 22;

	// 16K windows
	localparam int OFFS_W = 14;
	localparam int N_WIN  = 4;

endpackage

/* hw/zx_map_pkg.sv */
package zx_map_pkg;

	// paging ports
	localparam logic [15:0] PORT_7FFD = 16'h7FFD;
	localparam logic [15:0] PORT_EFF7 = 16'hEFF7;

	// atm window ports xFF7 with the window in a[15:14]
	localparam logic [7:0] ATM_PORT_LO  = 8'hF7;
	localparam logic [5:0] ATM_PORT_MID = 6'h3F;

	localparam int PAGE_W     = 8;
	localparam int ROM_PAGE_W = 2;

	// fixed ram pages of pentagon windows 1 and 2
	localparam logic [PAGE_W-1:0] WIN1_PAGE = 8'd5;
	localparam logic [PAGE_W-1:0] WIN2_PAGE = 8'd2;

	// rom pages
	localparam logic [ROM_PAGE_W-1:0] ROM_DOS_PAGE   = 2'd2;
	localparam logic [ROM_PAGE_W-1:0] ROM_BASIC_PAGE = 2'd1;

	localparam logic [7:0] DOS_TRAP_HI = 8'h3D;

	// idle bus
	localparam logic [7:0] FF_BUS = 8'hFF;

endpackage

/* hw/pager_if.sv */
`timescale 1ns/1ps

// accepted cpu cycle as seen by the port decoder and dos logic
interface bus_if import zx_bus_pkg::*; ();
	logic              acc;
	req_kind_e         kind;
	logic [CPU_AW-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic [DATA_W-1:0] io_rdata;

	modport master (output acc, kind, addr, wdata, input io_rdata);
	modport port (input acc, kind, addr, wdata, output io_rdata);
	modport monitor (input acc, kind, addr);
endinterface

// paging state from the port decoder to the window pagers
interface pager_if import zx_bus_pkg::*, zx_map_pkg::*; ();
	logic [7:0]               p7ffd;
	logic                     atm_on;
	logic                     atm_wr;
	logic [$clog2(N_WIN)-1:0] atm_window;
	logic [PAGE_W-1:0]        atm_data;

	modport decoder (output p7ffd, atm_on, atm_wr, atm_window, atm_data);
	modport pager (input p7ffd, atm_on, atm_wr, atm_window, atm_data);
endinterface

/* hw/port_decoder.sv */
`timescale 1ns/1ps

module port_decoder
	import zx_bus_pkg::*, zx_map_pkg::*;
(
	input  logic  fclk,
	input  logic  arst_n,
	bus_if.port   bus,
	pager_if.decoder pg
);

	logic [7:0]        p7ffd_q;
	logic [7:0]        peff7_q;
	logic [PAGE_W-1:0] atm_copy [N_WIN];

	logic io_wr;
	logic hit_7ffd;
	logic hit_eff7;
	logic hit_atm;

	assign io_wr    = bus.acc && (bus.kind == IO_WR);
	assign hit_7ffd = (bus.addr == PORT_7FFD);
	assign hit_eff7 = (bus.addr == PORT_EFF7);
	assign hit_atm  = (bus.addr[7:0] == ATM_PORT_LO) && (bus.addr[13:8] == ATM_PORT_MID);

	////////////////////////////////////////////////////////////
	// paging registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			p7ffd_q <= '0;
			peff7_q <= '0;
			for (int i = 0; i < N_WIN; i++)
				atm_copy[i] <= '0;
		end
		else if (io_wr)
		begin
			// bit 5 locks 7ffd until reset
			if (hit_7ffd && !p7ffd_q[5])
				p7ffd_q <= bus.wdata;
			if (hit_eff7)
				peff7_q <= bus.wdata;
			if (hit_atm)
				atm_copy[bus.addr[CPU_AW-1:OFFS_W]] <= bus.wdata;
		end
	end

	assign pg.p7ffd      = p7ffd_q;
	assign pg.atm_on     = peff7_q[0];
	assign pg.atm_wr     = io_wr && hit_atm;
	assign pg.atm_window = bus.addr[CPU_AW-1:OFFS_W];
	assign pg.atm_data   = bus.wdata;

	// undecoded ports float high
	always_comb
	begin
		if (hit_7ffd)
			bus.io_rdata = p7ffd_q;
		else if (hit_eff7)
			bus.io_rdata = peff7_q;
		else if (hit_atm)
			bus.io_rdata = atm_copy[bus.addr[CPU_AW-1:OFFS_W]];
		else
			bus.io_rdata = FF_BUS;
	end

endmodule

/* hw/window_pager.sv */
`timescale 1ns/1ps

module window_pager
	import zx_bus_pkg::*, zx_map_pkg::*;
#(
	parameter int WINDOW = 0
)
(
	input  logic              fclk,
	input  logic              arst_n,
	input  logic              dos,
	pager_if.pager            pg,
	output logic [PAGE_W-1:0] page,
	output logic              romnram
);

	logic [PAGE_W-1:0] atm_reg;

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			atm_reg <= '0;
		else if (pg.atm_wr && (pg.atm_window == WINDOW))
			atm_reg <= pg.atm_data;
	end

	always_comb
	begin
		if (pg.atm_on)
		begin
			// bit 7 selects ram
			romnram = ~atm_reg[7];
			if (atm_reg[7])
				page = {1'b0, atm_reg[6:0]};
			else
				page = PAGE_W'(atm_reg[ROM_PAGE_W-1:0]);
		end
		else
		begin
			case (WINDOW)
				1:
				begin
					romnram = 1'b0;
					page    = WIN1_PAGE;
				end
				2:
				begin
					romnram = 1'b0;
					page    = WIN2_PAGE;
				end
				3:
				begin
					romnram = 1'b0;
					page    = PAGE_W'(pg.p7ffd[2:0]);
				end
				default:
				begin
					romnram = 1'b1;
					page    = dos ? PAGE_W'(ROM_DOS_PAGE) : PAGE_W'(pg.p7ffd[4]);
				end
			endcase
		end
	end

endmodule

/* hw/dos_control.sv */
`timescale 1ns/1ps

module dos_control
	import zx_bus_pkg::*, zx_map_pkg::*;
(
	input  logic              fclk,
	input  logic              arst_n,
	input  logic [PAGE_W-1:0] win0_page,
	input  logic              win0_romnram,
	bus_if.monitor            bus,
	output logic              dos
);

	logic fetch;
	logic turn_on;
	logic turn_off;

	assign fetch = bus.acc && (bus.kind == FETCH);

	// trap only from the basic rom
	assign turn_on  = fetch && (bus.addr[CPU_AW-1:8] == DOS_TRAP_HI) &&
	                  win0_romnram && (win0_page == PAGE_W'(ROM_BASIC_PAGE));
	assign turn_off = fetch && (bus.addr[CPU_AW-1:OFFS_W] != '0);

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			dos <= 1'b0;
		else if (turn_on)
			dos <= 1'b1;
		else if (turn_off)
			dos <= 1'b0;
	end

endmodule

/* hw/mem_translator.sv */
`timescale 1ns/1ps

module mem_translator
	import zx_bus_pkg::*, zx_map_pkg::*;
(
	input  logic               fclk,
	input  logic               arst_n,
	input  logic               req_valid,
	input  req_kind_e          req_kind,
	input  logic [CPU_AW-1:0]  req_addr,
	input  logic [DATA_W-1:0]  req_wdata,
	output logic               req_ready,
	output logic               rsp_valid,
	output logic [DATA_W-1:0]  rsp_data,
	output logic               mem_valid,
	output logic               mem_we,
	output logic               mem_rom,
	output logic [PHYS_AW-1:0] mem_addr,
	output logic [DATA_W-1:0]  mem_wdata,
	input  logic               mem_ready,
	input  logic               mem_rvalid,
	input  logic [DATA_W-1:0]  mem_rdata,
	input  logic [PAGE_W-1:0]  page [N_WIN],
	input  logic [N_WIN-1:0]   romnram,
	bus_if.master              bus
);

	logic                     rd_pend;
	logic                     is_io;
	logic                     is_rd;
	logic                     slot_free;
	logic                     acc;
	logic                     load;
	logic [$clog2(N_WIN)-1:0] win;

	assign is_io     = (req_kind == IO_RD) || (req_kind == IO_WR);
	assign is_rd     = (req_kind == MEM_RD) || (req_kind == FETCH);
	assign slot_free = !mem_valid || mem_ready;

	// i/o waits for the memory side to drain
	assign req_ready = !rd_pend && (is_io ? !mem_valid : slot_free);
	assign acc       = req_valid && req_ready;
	assign win       = req_addr[CPU_AW-1:OFFS_W];

	// rom writes vanish here
	assign load = acc && !is_io && !((req_kind == MEM_WR) && romnram[win]);

	assign bus.acc   = acc;
	assign bus.kind  = req_kind;
	assign bus.addr  = req_addr;
	assign bus.wdata = req_wdata;

	////////////////////////////////////////////////////////////
	// output register
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			mem_valid <= 1'b0;
		else if (load)
			mem_valid <= 1'b1;
		else if (mem_ready)
			mem_valid <= 1'b0;
	end

	always_ff @(posedge fclk)
	begin
		if (load)
		begin
			mem_we    <= (req_kind == MEM_WR);
			mem_rom   <= romnram[win];
			mem_addr  <= {page[win], req_addr[OFFS_W-1:0]};
			mem_wdata <= req_wdata;
		end
	end

	////////////////////////////////////////////////////////////
	// reads and responses
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rd_pend   <= 1'b0;
			rsp_valid <= 1'b0;
		end
		else
		begin
			if (acc && is_rd)
				rd_pend <= 1'b1;
			else if (mem_rvalid)
				rd_pend <= 1'b0;
			rsp_valid <= (acc && (req_kind == IO_RD)) || (mem_rvalid && rd_pend);
		end
	end

	always_ff @(posedge fclk)
	begin
		if (mem_rvalid)
			rsp_data <= mem_rdata;
		else if (acc && (req_kind == IO_RD))
			rsp_data <= bus.io_rdata;
	end

endmodule

/* hw/zx_mem_top.sv */
`timescale 1ns/1ps

module zx_mem_top
	import zx_bus_pkg::*, zx_map_pkg::*;
(
	input  logic               fclk,
	input  logic               arst_n,
	input  logic               req_valid,
	input  req_kind_e          req_kind,
	input  logic [CPU_AW-1:0]  req_addr,
	input  logic [DATA_W-1:0]  req_wdata,
	output logic               req_ready,
	output logic               rsp_valid,
	output logic [DATA_W-1:0]  rsp_data,
	output logic               mem_valid,
	output logic               mem_we,
	output logic               mem_rom,
	output logic [PHYS_AW-1:0] mem_addr,
	output logic [DATA_W-1:0]  mem_wdata,
	input  logic               mem_ready,
	input  logic               mem_rvalid,
	input  logic [DATA_W-1:0]  mem_rdata
);

	bus_if   bus0 ();
	pager_if pg0 ();

	logic [PAGE_W-1:0] win_page [N_WIN];
	logic [N_WIN-1:0]  win_romnram;
	logic              dos;

	mem_translator u_translator (
		.fclk       (fclk),
		.arst_n     (arst_n),
		.req_valid  (req_valid),
		.req_kind   (req_kind),
		.req_addr   (req_addr),
		.req_wdata  (req_wdata),
		.req_ready  (req_ready),
		.rsp_valid  (rsp_valid),
		.rsp_data   (rsp_data),
		.mem_valid  (mem_valid),
		.mem_we     (mem_we),
		.mem_rom    (mem_rom),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_ready  (mem_ready),
		.mem_rvalid (mem_rvalid),
		.mem_rdata  (mem_rdata),
		.page       (win_page),
		.romnram    (win_romnram),
		.bus        (bus0.master)
	);

	port_decoder u_ports (
		.fclk   (fclk),
		.arst_n (arst_n),
		.bus    (bus0.port),
		.pg     (pg0.decoder)
	);

	// one pager per 16K window
	for (genvar w = 0; w < N_WIN; w++)
	begin : g_win
		window_pager #(.WINDOW(w)) u_pager (
			.fclk    (fclk),
			.arst_n  (arst_n),
			.dos     (dos),
			.pg      (pg0.pager),
			.page    (win_page[w]),
			.romnram (win_romnram[w])
		);
	end

	dos_control u_dos (
		.fclk         (fclk),
		.arst_n       (arst_n),
		.win0_page    (win_page[0]),
		.win0_romnram (win_romnram[0]),
		.bus          (bus0.monitor),
		.dos          (dos)
	);

endmodule

/* bench/zx_mem_chk.sv */
`timescale 1ns/1ps

module zx_mem_chk
	import zx_bus_pkg::*;
(
	input logic               fclk,
	input logic               arst_n,
	input logic               req_valid,
	input req_kind_e          req_kind,
	input logic               req_ready,
	input logic               rsp_valid,
	input logic               mem_valid,
	input logic               mem_we,
	input logic               mem_rom,
	input logic [PHYS_AW-1:0] mem_addr,
	input logic [DATA_W-1:0]  mem_wdata,
	input logic               mem_ready,
	input logic               mem_rvalid
);

	// a waiting memory request holds still
	a_mem_hold: assert property (@(posedge fclk) disable iff (!arst_n)
		mem_valid && !mem_ready |=> mem_valid && $stable({mem_we, mem_rom, mem_addr, mem_wdata}))
		else $error("memory request dropped or changed before mem_ready");

	a_in_reset: assert property (@(posedge fclk) !arst_n |-> !mem_valid && !rsp_valid)
		else $error("memory request or response during reset");

	a_after_reset: assert property (@(posedge fclk)
		$rose(arst_n) |-> req_ready && !mem_valid && !rsp_valid)
		else $error("wrong handshake state after reset");

	// response needs a returned read or an i/o read one cycle before
	a_rsp_source: assert property (@(posedge fclk) disable iff (!arst_n)
		rsp_valid |-> $past(mem_rvalid || (req_valid && req_ready && req_kind == IO_RD)))
		else $error("response with no read pending");

endmodule

bind zx_mem_top zx_mem_chk chk0 (.*);

/* bench/zx_mem_tb.sv */
`timescale 1ns/1ps

module zx_mem_tb
	import zx_bus_pkg::*;
();

	logic               fclk;
	logic               arst_n;
	logic               req_valid;
	req_kind_e          req_kind;
	logic [CPU_AW-1:0]  req_addr;
	logic [DATA_W-1:0]  req_wdata;
	logic               req_ready;
	logic               rsp_valid;
	logic [DATA_W-1:0]  rsp_data;
	logic               mem_valid;
	logic               mem_we;
	logic               mem_rom;
	logic [PHYS_AW-1:0] mem_addr;
	logic [DATA_W-1:0]  mem_wdata;
	logic               mem_ready;
	logic               mem_rvalid;
	logic [DATA_W-1:0]  mem_rdata;

	// reference state
	logic [15:0] lfsr;
	logic [7:0]  m7ffd;
	logic [7:0]  meff7;
	logic [7:0]  matm [4];
	logic        mdos;
	logic [31:0] exp_mem [$];
	logic [7:0]  exp_rsp [$];
	int          rd_wait;
	logic [21:0] rd_addr;
	logic        took;
	logic        rsp_due;

	zx_mem_top dut0 (.*);

	initial
	begin
		fclk = 1'b0;
		forever #2 fclk = ~fclk;
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] take_bits(int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			r    = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return r;
	endfunction

	function automatic logic [7:0] fold_addr(logic [21:0] a);
		return a[7:0] ^ a[15:8] ^ {2'b00, a[21:16]};
	endfunction

	function automatic logic is_atm(logic [15:0] a);
		return (a[7:0] == 8'hF7) && (a[13:8] == 6'h3F);
	endfunction

	function automatic logic [7:0] io_read(logic [15:0] a);
		if (a == 16'h7FFD)
			return m7ffd;
		if (a == 16'hEFF7)
			return meff7;
		if (is_atm(a))
			return matm[a[15:14]];
		return 8'hFF;
	endfunction

	task automatic abort_run();
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic map_window(input logic [1:0] w, output logic [7:0] pg, output logic rom);
		if (meff7[0])
		begin
			rom = !matm[w][7];
			pg  = matm[w][7] ? {1'b0, matm[w][6:0]} : {6'd0, matm[w][1:0]};
		end
		else
		begin
			rom = (w == 2'd0);
			case (w)
				2'd0: pg = mdos ? 8'd2 : {7'd0, m7ffd[4]};
				2'd1: pg = 8'd5;
				2'd2: pg = 8'd2;
				default: pg = {5'd0, m7ffd[2:0]};
			endcase
		end
	endtask

	// effect of the request accepted at the coming edge
	task automatic model_accept();
		logic [7:0]  pg;
		logic        rom;
		logic [21:0] pa;
		logic [7:0]  p0;
		logic        r0;
		map_window(req_addr[15:14], pg, rom);
		pa = {pg, req_addr[13:0]};
		case (req_kind)
			MEM_RD, FETCH:
			begin
				exp_mem.push_back({1'b0, rom, pa, req_wdata});
				exp_rsp.push_back(fold_addr(pa));
				if (req_kind == FETCH)
				begin
					map_window(2'd0, p0, r0);
					if (req_addr[15:8] == 8'h3D && r0 && p0 == 8'd1)
						mdos = 1'b1;
					else if (req_addr[15:14] != 2'd0)
						mdos = 1'b0;
				end
			end
			MEM_WR:
			begin
				if (!rom)
					exp_mem.push_back({1'b1, 1'b0, pa, req_wdata});
			end
			IO_RD:
				exp_rsp.push_back(io_read(req_addr));
			default:
			begin
				if (req_addr == 16'h7FFD && !m7ffd[5])
					m7ffd = req_wdata;
				if (req_addr == 16'hEFF7)
					meff7 = req_wdata;
				if (is_atm(req_addr))
					matm[req_addr[15:14]] = req_wdata;
			end
		endcase
	endtask

	////////////////////////////////////////////////////////////
	// per cycle sampling and driving
	////////////////////////////////////////////////////////////

	task automatic observe();
		logic [31:0] e;
		compare("rsp_valid", rsp_valid, rsp_due);
		if (rsp_valid)
		begin
			if (exp_rsp.size() == 0)
			begin
				$display("response arrived with no read waiting");
				abort_run();
			end
			else
				compare("rsp_data", rsp_data, exp_rsp.pop_front());
		end
		if (mem_valid && mem_ready)
		begin
			if (exp_mem.size() == 0)
			begin
				$display("memory transaction issued when none was expected");
				abort_run();
			end
			else
			begin
				e = exp_mem.pop_front();
				compare("mem_we", mem_we, e[31]);
				compare("mem_rom", mem_rom, e[30]);
				compare("mem_addr", mem_addr, e[29:8]);
				if (e[31])
					compare("mem_wdata", mem_wdata, e[7:0]);
				else
				begin
					rd_wait = 1 + take_bits(3) % 6;
					rd_addr = mem_addr;
				end
			end
		end
		took    = req_valid && req_ready;
		rsp_due = mem_rvalid || (took && req_kind == IO_RD);
		if (took)
			model_accept();
	endtask

	task automatic drive_memory();
		mem_rvalid = 1'b0;
		if (rd_wait > 0)
		begin
			rd_wait--;
			if (rd_wait == 0)
			begin
				mem_rvalid = 1'b1;
				mem_rdata  = fold_addr(rd_addr);
			end
		end
		mem_ready = (take_bits(2) != 0);
	endtask

	task automatic tick();
		@(negedge fclk);
		observe();
		@(posedge fclk);
		#0.5;
		if (took)
			req_valid = 1'b0;
		drive_memory();
	endtask

	task automatic send(input req_kind_e k, input logic [15:0] a, input logic [7:0] d);
		int waited;
		req_valid = 1'b1;
		req_kind  = k;
		req_addr  = a;
		req_wdata = d;
		waited    = 0;
		tick();
		while (!took)
		begin
			waited++;
			if (waited > 200)
			begin
				$display("request at address %h was not accepted in time", a);
				abort_run();
			end
			tick();
		end
	endtask

	// weighted toward paging ports, 3Dxx and window 3
	task automatic random_request();
		logic [2:0]  sel;
		logic [31:0] r;
		logic [15:0] a;
		logic [7:0]  d;
		req_kind_e   k;
		sel = take_bits(3);
		d   = take_bits(8);
		r   = take_bits(16);
		a   = (take_bits(2) == 0) ? {2'b11, r[13:0]} : r[15:0];
		case (sel)
			3'd0, 3'd1, 3'd2:
			begin
				k = (sel == 3'd2) ? IO_RD : IO_WR;
				case (take_bits(2))
					2'd0: a = 16'h7FFD;
					2'd1: a = 16'hEFF7;
					2'd2: a = {a[15:14], 6'h3F, 8'hF7};
					default: a = a;
				endcase
			end
			3'd3:
			begin
				k = FETCH;
				a = {8'h3D, a[7:0]};
			end
			3'd4: k = FETCH;
			3'd5: k = MEM_RD;
			default: k = MEM_WR;
		endcase
		// lock stays off until the final section
		if (a == 16'h7FFD)
			d[5] = 1'b0;
		send(k, a, d);
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		int waited;
		arst_n     = 1'b0;
		req_valid  = 1'b0;
		req_kind   = MEM_RD;
		req_addr   = '0;
		req_wdata  = '0;
		mem_ready  = 1'b0;
		mem_rvalid = 1'b0;
		mem_rdata  = '0;
		lfsr       = 16'd32625;
		m7ffd      = '0;
		meff7      = '0;
		matm       = '{default: 8'h00};
		mdos       = 1'b0;
		rd_wait    = 0;
		rd_addr    = '0;
		took       = 1'b0;
		rsp_due    = 1'b0;
		repeat (16) @(posedge fclk);
		#0.5;
		arst_n = 1'b1;
		@(negedge fclk);
		compare("req_ready", req_ready, 1);
		compare("mem_valid", mem_valid, 0);
		compare("rsp_valid", rsp_valid, 0);
		@(posedge fclk);
		#0.5;

		// pentagon map then 7ffd paging and rom write drop
		send(MEM_RD, 16'h0123, 8'h00);
		send(MEM_RD, 16'h4123, 8'h00);
		send(MEM_RD, 16'h8123, 8'h00);
		send(MEM_RD, 16'hC123, 8'h00);
		send(IO_WR, 16'h7FFD, 8'h13);
		send(MEM_RD, 16'hC001, 8'h00);
		send(MEM_WR, 16'h0001, 8'hA5);
		send(MEM_WR, 16'hC002, 8'h5A);

		// dos trap in and out
		send(FETCH, 16'h3D2F, 8'h00);
		send(MEM_RD, 16'h0005, 8'h00);
		send(FETCH, 16'h4000, 8'h00);
		send(MEM_RD, 16'h0005, 8'h00);
		send(IO_RD, 16'h7FFD, 8'h00);
		send(IO_RD, 16'h00FE, 8'h00);

		// atm windows
		send(IO_WR, 16'hEFF7, 8'h01);
		send(IO_WR, 16'h3FF7, 8'h85);
		send(IO_WR, 16'h7FF7, 8'h03);
		send(IO_WR, 16'hBFF7, 8'hFF);
		send(IO_WR, 16'hFFF7, 8'h02);
		send(MEM_RD, 16'h0010, 8'h00);
		send(MEM_RD, 16'h4010, 8'h00);
		send(MEM_RD, 16'h8010, 8'h00);
		send(MEM_RD, 16'hC010, 8'h00);
		send(MEM_WR, 16'h4011, 8'h77);
		send(IO_RD, 16'h3FF7, 8'h00);
		send(IO_RD, 16'hBFF7, 8'h00);
		send(IO_RD, 16'hEFF7, 8'h00);
		send(IO_WR, 16'hEFF7, 8'h00);
		send(MEM_RD, 16'h0010, 8'h00);

		for (int n = 0; n < 1500; n++)
		begin
			random_request();
			if (take_bits(2) == 0)
				tick();
		end

		// 7ffd lock
		send(IO_WR, 16'h7FFD, 8'h24);
		send(IO_WR, 16'h7FFD, 8'h13);
		send(IO_RD, 16'h7FFD, 8'h00);
		send(MEM_RD, 16'hC000, 8'h00);

		waited = 0;
		while (exp_mem.size() != 0 || exp_rsp.size() != 0 || rd_wait != 0)
		begin
			waited++;
			if (waited > 500)
			begin
				$display("memory side did not drain in time");
				abort_run();
			end
			tick();
		end
		tick();

		$display("TEST PASS");
		$finish;
	end

endmodule

/* files.f */
hw/zx_bus_pkg.sv
hw/zx_map_pkg.sv
hw/pager_if.sv
hw/port_decoder.sv
hw/window_pager.sv
hw/dos_control.sv
hw/mem_translator.sv
hw/zx_mem_top.sv
bench/zx_mem_chk.sv
bench/zx_mem_tb.sv

/* Bender.yml */
package:
  name: zx_mem

sources:
  - files:
      - hw/zx_bus_pkg.sv
      - hw/zx_map_pkg.sv
      - hw/pager_if.sv
      - hw/port_decoder.sv
      - hw/window_pager.sv
      - hw/dos_control.sv
      - hw/mem_translator.sv
      - hw/zx_mem_top.sv
  - target: test
    files:
      - bench/zx_mem_chk.sv
      - bench/zx_mem_tb.sv
